// ==== project.f ====
+incdir+test
logic/iarb_pkg.sv
logic/cmd_arbiter.sv
logic/cmd_mux.sv
logic/pkt_track_fifo.sv
logic/rsp_switch.sv
logic/iarb_top.sv
test/iarb_tb.sv

// ==== Makefile ====
# Instruction-bus arbiter, Verilator flow

TOP := iarb_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-Mdir obj_dir -f project.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== test/iarb_ref.svh ====
// ==========================================================
// Arbiter reference model
// Expected grant from requests, packet hold and bus lock
// ==========================================================
`ifndef IARB_REF_SVH
`define IARB_REF_SVH

// Held or locked port keeps the bus, else lowest requester
function automatic iarb_pkg::port_idx_t ref_grant(
  input logic [iarb_pkg::NUM_PORTS-1:0] req,
  input bit                             held,
  input iarb_pkg::port_idx_t            held_port,
  input bit                             locked,
  input iarb_pkg::port_idx_t            lock_owner
);
  iarb_pkg::port_idx_t g;
  g = '0;
  if (held)
  begin
    g = held_port;
  end
  else if (locked)
  begin
    g = lock_owner;
  end
  else
  begin
    for (int i = 0; i < iarb_pkg::NUM_PORTS; i++)
    begin
      if (req[i])
      begin
        g = iarb_pkg::port_idx_t'(i);
        break;
      end
    end
  end
  return g;
endfunction

// One-hot port vector
function automatic logic [iarb_pkg::NUM_PORTS-1:0] port_bit(input iarb_pkg::port_idx_t p);
  logic [iarb_pkg::NUM_PORTS-1:0] v;
  v = '0;
  v[p] = 1'b1;
  return v;
endfunction

`endif

// ==== test/iarb_tb.sv ====
// ==========================================================
// Instruction-bus arbiter testbench
// Port drivers, initiator model, per-cycle reference check
// and directed priority, hold, lock and back-pressure runs
// ==========================================================
`timescale 1ns/1ps

module iarb_tb;

  localparam int NP         = iarb_pkg::NUM_PORTS;
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int FIFO_DEPTH = 4;
  localparam int WAIT_LIMIT = 200;

  logic                           clk        = 1'b0;
  logic                           rst_a      = 1'b1;
  logic [NP-1:0]                  i_t_cmdval = '0;
  iarb_pkg::cmd_t [NP-1:0]        i_t_cmd    = '0;
  logic [NP-1:0]                  i_t_eop    = '0;
  logic [NP-1:0][ADDR_W-1:0]      i_t_addr   = '0;
  logic [NP-1:0][DATA_W-1:0]      i_t_wdata  = '0;
  logic [NP-1:0]                  i_t_rspack = '0;
  logic                           i_m_cmdack = 1'b0;
  logic                           i_m_rspval = 1'b0;
  logic                           i_m_reop   = 1'b0;
  logic [DATA_W-1:0]              i_m_rdata  = '0;
  logic [NP-1:0]                  o_t_cmdack;
  logic [NP-1:0]                  o_t_rspval;
  logic [DATA_W-1:0]              o_t_rdata;
  logic                           o_t_reop;
  logic                           o_m_cmdval;
  iarb_pkg::cmd_t                 o_m_cmd;
  logic                           o_m_eop;
  logic [ADDR_W-1:0]              o_m_addr;
  logic [DATA_W-1:0]              o_m_wdata;
  logic                           o_m_rspack;
  logic                           o_busy;

  // Model state, updated once per cycle by the compare process
  bit                  hold_on   = 1'b0;
  bit                  lock_on   = 1'b0;
  iarb_pkg::port_idx_t hold_port = '0;
  iarb_pkg::port_idx_t lock_port = '0;
  iarb_pkg::port_idx_t pend_port[$];
  logic [ADDR_W-1:0]   pend_addr[$];
  int                  issued_log[$];
  int                  exp_log[$];
  // Completed packets waiting for an initiator response
  logic [ADDR_W-1:0]   done_q[$];
  bit                  rsp_stall = 1'b0;
  int                  err_cnt   = 0;
  int                  tmo_cnt   = 0;

  `include "iarb_ref.svh"

  iarb_top #(
    .ADDR_W     (ADDR_W),
    .DATA_W     (DATA_W),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) DUT (
    .clk        (clk),
    .rst_a      (rst_a),
    .i_t_cmdval (i_t_cmdval),
    .i_t_cmd    (i_t_cmd),
    .i_t_eop    (i_t_eop),
    .i_t_addr   (i_t_addr),
    .i_t_wdata  (i_t_wdata),
    .i_t_rspack (i_t_rspack),
    .o_t_cmdack (o_t_cmdack),
    .o_t_rspval (o_t_rspval),
    .o_t_rdata  (o_t_rdata),
    .o_t_reop   (o_t_reop),
    .o_m_cmdval (o_m_cmdval),
    .o_m_cmd    (o_m_cmd),
    .o_m_eop    (o_m_eop),
    .o_m_addr   (o_m_addr),
    .o_m_wdata  (o_m_wdata),
    .o_m_rspack (o_m_rspack),
    .i_m_cmdack (i_m_cmdack),
    .i_m_rspval (i_m_rspval),
    .i_m_reop   (i_m_reop),
    .i_m_rdata  (i_m_rdata),
    .o_busy     (o_busy)
  );

  always #2 clk = ~clk;

  task automatic report_mismatch(input string msg);
    err_cnt++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  task automatic report_timeout(input string what);
    tmo_cnt++;
    $display("Timed out at %0t waiting for %s", $time, what);
  endtask

  // ========================================================
  // Port driver, same address on every beat of a packet
  // ========================================================

  task automatic send_pkt(
    input iarb_pkg::port_idx_t p,
    input iarb_pkg::cmd_t      cmd,
    input int                  beats,
    input logic [ADDR_W-1:0]   addr
  );
    int t;
    for (int b = 0; b < beats; b++)
    begin
      @(posedge clk);
      i_t_cmdval[p] <= 1'b1;
      i_t_cmd[p]    <= cmd;
      i_t_eop[p]    <= (b == beats - 1);
      i_t_addr[p]   <= addr;
      i_t_wdata[p]  <= $urandom;
      t = 0;
      @(negedge clk);
      while (!o_t_cmdack[p] && t < WAIT_LIMIT)
      begin
        @(negedge clk);
        t++;
      end
      if (!o_t_cmdack[p])
      begin
        report_timeout($sformatf("command acknowledge on port %0d", p));
        break;
      end
    end
    // Beat transfers on this edge
    @(posedge clk);
    i_t_cmdval[p] <= 1'b0;
    i_t_eop[p]    <= 1'b0;
  endtask

  task automatic send_mix(input iarb_pkg::port_idx_t p);
    for (int k = 0; k < 3; k++)
    begin
      send_pkt(p, ($urandom_range(1, 0) == 0) ? iarb_pkg::CMD_READ : iarb_pkg::CMD_WRITE,
        $urandom_range(3, 1), $urandom);
    end
  endtask

  task automatic wait_idle();
    int t;
    t = 0;
    @(negedge clk);
    while ((o_busy || done_q.size() != 0) && t < WAIT_LIMIT)
    begin
      @(negedge clk);
      t++;
    end
    if (o_busy)
    begin
      report_timeout("busy to fall");
    end
    @(posedge clk);
    assert (pend_port.size() == 0)
      else report_mismatch($sformatf("%0d packets never answered", pend_port.size()));
  endtask

  task automatic check_order();
    assert (issued_log.size() == exp_log.size())
      else report_mismatch($sformatf("%0d packets issued, expected %0d",
        issued_log.size(), exp_log.size()));
    for (int i = 0; i < exp_log.size() && i < issued_log.size(); i++)
    begin
      assert (issued_log[i] == exp_log[i])
        else report_mismatch($sformatf("packet %0d from port %0d, expected port %0d",
          i, issued_log[i], exp_log[i]));
    end
    issued_log.delete();
  endtask

  // ========================================================
  // Initiator model
  // ========================================================

  // Random acknowledge gaps on both sides
  always @(posedge clk)
  begin
    if (rst_a)
    begin
      i_m_cmdack <= 1'b0;
      i_t_rspack <= '0;
    end
    else
    begin
      i_m_cmdack <= ($urandom_range(2, 0) != 0);
      i_t_rspack <= NP'($urandom);
    end
  end

  always @(negedge clk)
  begin
    if (!rst_a && o_m_cmdval && i_m_cmdack && o_m_eop)
    begin
      done_q.push_back(o_m_addr);
    end
  end

  // One or two response beats, data is the packet address
  initial
  begin : initiator_rsp
    logic [ADDR_W-1:0] addr;
    int                beats;
    int                t;
    forever
    begin
      @(posedge clk);
      if (done_q.size() != 0 && !rsp_stall)
      begin
        addr  = done_q.pop_front();
        beats = $urandom_range(2, 1);
        for (int b = 0; b < beats; b++)
        begin
          i_m_rspval <= 1'b1;
          i_m_rdata  <= addr;
          i_m_reop   <= (b == beats - 1);
          t = 0;
          @(negedge clk);
          while (!o_m_rspack && t < WAIT_LIMIT)
          begin
            @(negedge clk);
            t++;
          end
          if (!o_m_rspack)
          begin
            report_timeout("response acknowledge");
          end
          @(posedge clk);
        end
        i_m_rspval <= 1'b0;
        i_m_reop   <= 1'b0;
      end
    end
  end

  // ========================================================
  // Per-cycle comparison against the reference model
  // ========================================================

  always @(negedge clk)
  begin : compare
    logic [NP-1:0]       exp_ack;
    logic [NP-1:0]       exp_rspval;
    iarb_pkg::port_idx_t g;
    iarb_pkg::port_idx_t owner;
    bit                  exp_val;
    bit                  retire;
    if (!rst_a)
    begin
      g          = ref_grant(i_t_cmdval, hold_on, hold_port, lock_on, lock_port);
      // Full FIFO blocks only a new packet
      exp_val    = !(pend_port.size() == FIFO_DEPTH && !hold_on) && i_t_cmdval[g];
      exp_ack    = (exp_val && i_m_cmdack) ? port_bit(g) : '0;
      owner      = (pend_port.size() != 0) ? pend_port[0] : g;
      exp_rspval = i_m_rspval ? port_bit(owner) : '0;
      assert (o_m_cmdval == exp_val)
        else report_mismatch($sformatf("initiator valid %0b, expected %0b", o_m_cmdval, exp_val));
      if (exp_val)
      begin
        assert (o_m_addr == i_t_addr[g] && o_m_cmd == i_t_cmd[g] && o_m_eop == i_t_eop[g]
            && o_m_wdata == i_t_wdata[g])
          else report_mismatch($sformatf("initiator fields not from port %0d", g));
      end
      assert ((o_t_cmdack & i_t_cmdval) == exp_ack)
        else report_mismatch($sformatf("command ack %b, expected %b", o_t_cmdack, exp_ack));
      assert (o_t_rspval == exp_rspval)
        else report_mismatch($sformatf("response valid %b, expected %b", o_t_rspval, exp_rspval));
      assert (o_m_rspack == i_t_rspack[owner])
        else report_mismatch($sformatf("response ack not from port %0d", owner));
      if (i_m_rspval && pend_port.size() != 0)
      begin
        assert (o_t_rdata == pend_addr[0] && o_t_reop == i_m_reop)
          else report_mismatch($sformatf("port %0d read data %h, expected %h",
            owner, o_t_rdata, pend_addr[0]));
      end
      assert (o_busy == (pend_port.size() != 0))
        else report_mismatch($sformatf("busy %0b with %0d outstanding", o_busy, pend_port.size()));

      // Retire before issue, both apply at the coming edge
      retire = i_m_rspval && i_t_rspack[owner] && i_m_reop && (pend_port.size() != 0);
      if (retire)
      begin
        void'(pend_port.pop_front());
        void'(pend_addr.pop_front());
      end
      if (!hold_on && exp_val)
      begin
        pend_port.push_back(g);
        pend_addr.push_back(i_t_addr[g]);
        issued_log.push_back(int'(g));
        if (!lock_on && i_t_cmd[g] == iarb_pkg::CMD_LOCK)
        begin
          lock_on   = 1'b1;
          lock_port = g;
        end
        else if (lock_on && i_t_cmd[g] == iarb_pkg::CMD_UNLOCK)
        begin
          lock_on = 1'b0;
        end
        // Single beat acked now needs no hold
        if (!(i_m_cmdack && i_t_eop[g]))
        begin
          hold_on   = 1'b1;
          hold_port = g;
        end
      end
      else if (hold_on && exp_val && i_m_cmdack && i_t_eop[g])
      begin
        hold_on = 1'b0;
      end
    end
  end

  // ========================================================
  // Scenario sequence
  // ========================================================

  initial
  begin
    void'($urandom(32'h2cd697bb));
    repeat (10) @(posedge clk);
    rst_a <= 1'b0;

    // Quiet bus right after reset
    @(negedge clk);
    assert (o_t_cmdack == '0 && o_t_rspval == '0 && !o_m_rspack && !o_busy && !o_m_cmdval)
      else report_mismatch("outputs not idle after reset");

    // Lowest requester wins
    fork
      send_pkt(3'd4, iarb_pkg::CMD_READ, 1, $urandom);
      send_pkt(3'd2, iarb_pkg::CMD_WRITE, 1, $urandom);
      send_pkt(3'd1, iarb_pkg::CMD_READ, 1, $urandom);
    join
    exp_log = '{1, 2, 4};
    check_order();
    wait_idle();

    // Port 0 arrives mid-packet
    fork
      send_pkt(3'd3, iarb_pkg::CMD_WRITE, 4, $urandom);
      begin
        repeat (2) @(posedge clk);
        send_pkt(3'd0, iarb_pkg::CMD_READ, 1, $urandom);
      end
    join
    exp_log = '{3, 0};
    check_order();
    wait_idle();

    // Locked bus stays with port 2 until UNLOCK
    fork
      begin
        send_pkt(3'd2, iarb_pkg::CMD_LOCK, 1, $urandom);
        send_pkt(3'd2, iarb_pkg::CMD_READ, 1, $urandom);
        send_pkt(3'd2, iarb_pkg::CMD_WRITE, 2, $urandom);
        send_pkt(3'd2, iarb_pkg::CMD_UNLOCK, 1, $urandom);
      end
      begin
        repeat (3) @(posedge clk);
        send_pkt(3'd0, iarb_pkg::CMD_READ, 1, $urandom);
      end
    join
    exp_log = '{2, 2, 2, 2, 0};
    check_order();
    wait_idle();

    // All ports at once, mixed lengths
    fork
      send_mix(3'd0);
      send_mix(3'd1);
      send_mix(3'd2);
      send_mix(3'd3);
      send_mix(3'd4);
    join
    wait_idle();
    issued_log.delete();

    // Fill the FIFO with responses withheld
    rsp_stall = 1'b1;
    repeat (FIFO_DEPTH) send_pkt(3'd1, iarb_pkg::CMD_READ, 1, $urandom);
    fork
      send_pkt(3'd4, iarb_pkg::CMD_READ, 1, $urandom);
      begin
        repeat (6) @(negedge clk);
        assert (!o_m_cmdval && o_t_cmdack == '0 && o_busy)
          else report_mismatch("request served while FIFO full");
        rsp_stall = 1'b0;
      end
    join
    exp_log = '{1, 1, 1, 1, 4};
    check_order();
    wait_idle();

    $display("Checks done: %0d mismatches, %0d timeouts", err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0)
    begin
      $display("Test OK");
    end
    else
    begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== logic/iarb_top.sv ====
// ==========================================================
// Instruction-bus arbiter top level
// Five requesting ports share one initiator bus, responses
// return to ports in issue order
// ==========================================================
`timescale 1ns/1ps

module iarb_top #(
  parameter int ADDR_W     = 32,
  parameter int DATA_W     = 32,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                                         clk,
  input  logic                                         rst_a,
  // Requesting ports
  input  logic [iarb_pkg::NUM_PORTS-1:0]               i_t_cmdval,
  input  iarb_pkg::cmd_t [iarb_pkg::NUM_PORTS-1:0]     i_t_cmd,
  input  logic [iarb_pkg::NUM_PORTS-1:0]               i_t_eop,
  input  logic [iarb_pkg::NUM_PORTS-1:0][ADDR_W-1:0]   i_t_addr,
  input  logic [iarb_pkg::NUM_PORTS-1:0][DATA_W-1:0]   i_t_wdata,
  input  logic [iarb_pkg::NUM_PORTS-1:0]               i_t_rspack,
  output logic [iarb_pkg::NUM_PORTS-1:0]               o_t_cmdack,
  output logic [iarb_pkg::NUM_PORTS-1:0]               o_t_rspval,
  output logic [DATA_W-1:0]                            o_t_rdata,
  output logic                                         o_t_reop,
  // Initiator bus
  output logic                                         o_m_cmdval,
  output iarb_pkg::cmd_t                               o_m_cmd,
  output logic                                         o_m_eop,
  output logic [ADDR_W-1:0]                            o_m_addr,
  output logic [DATA_W-1:0]                            o_m_wdata,
  output logic                                         o_m_rspack,
  input  logic                                         i_m_cmdack,
  input  logic                                         i_m_rspval,
  input  logic                                         i_m_reop,
  input  logic [DATA_W-1:0]                            i_m_rdata,
  // Status
  output logic                                         o_busy
);

  iarb_pkg::port_idx_t cmd_sel;
  iarb_pkg::port_idx_t fifo_head;
  iarb_pkg::port_idx_t rsp_sel;
  logic                cmd_inhibit;
  logic                fifo_load;
  logic                fifo_full;
  logic                fifo_empty;
  logic                rsp_unload;

  // ========================================================
  // Command path
  // ========================================================

  cmd_arbiter u_cmd_arbiter (
    .clk          (clk),
    .rst_a        (rst_a),
    .i_cmdval     (i_t_cmdval),
    .i_sel_cmdval (o_m_cmdval),
    .i_sel_cmd    (o_m_cmd),
    .i_sel_eop    (o_m_eop),
    .i_m_cmdack   (i_m_cmdack),
    .i_fifo_full  (fifo_full),
    .o_sel        (cmd_sel),
    .o_inhibit    (cmd_inhibit),
    .o_load       (fifo_load)
  );

  cmd_mux #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W)
  ) u_cmd_mux (
    .i_sel      (cmd_sel),
    .i_inhibit  (cmd_inhibit),
    .i_t_cmdval (i_t_cmdval),
    .i_t_cmd    (i_t_cmd),
    .i_t_eop    (i_t_eop),
    .i_t_addr   (i_t_addr),
    .i_t_wdata  (i_t_wdata),
    .i_m_cmdack (i_m_cmdack),
    .o_m_cmdval (o_m_cmdval),
    .o_m_cmd    (o_m_cmd),
    .o_m_eop    (o_m_eop),
    .o_m_addr   (o_m_addr),
    .o_m_wdata  (o_m_wdata),
    .o_t_cmdack (o_t_cmdack)
  );

  // ========================================================
  // Packet tracking and response path
  // ========================================================

  pkt_track_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_pkt_track_fifo (
    .clk      (clk),
    .rst_a    (rst_a),
    .i_load   (fifo_load),
    .i_din    (cmd_sel),
    .i_unload (rsp_unload),
    .o_head   (fifo_head),
    .o_full   (fifo_full),
    .o_empty  (fifo_empty)
  );

  // Bypass to the live grant when nothing is outstanding
  assign rsp_sel = fifo_empty ? cmd_sel : fifo_head;

  rsp_switch u_rsp_switch (
    .i_rsp_sel  (rsp_sel),
    .i_m_rspval (i_m_rspval),
    .i_m_reop   (i_m_reop),
    .i_t_rspack (i_t_rspack),
    .o_t_rspval (o_t_rspval),
    .o_m_rspack (o_m_rspack),
    .o_unload   (rsp_unload)
  );

  // Read data and end flag are shared, valid picks the owner
  assign o_t_rdata = i_m_rdata;
  assign o_t_reop  = i_m_reop;

  // Busy while any packet awaits its response
  assign o_busy = !fifo_empty;

endmodule

// ==== logic/rsp_switch.sv ====
// ==========================================================
// Response switch
// Routes response valid to the owning port, returns its
// acknowledge and flags the end of each response
// ==========================================================
`timescale 1ns/1ps

module rsp_switch (
  input  iarb_pkg::port_idx_t            i_rsp_sel,
  input  logic                           i_m_rspval,
  input  logic                           i_m_reop,
  input  logic [iarb_pkg::NUM_PORTS-1:0] i_t_rspack,
  output logic [iarb_pkg::NUM_PORTS-1:0] o_t_rspval,
  output logic                           o_m_rspack,
  output logic                           o_unload
);

  // ========================================================
  // Valid switch and ack multiplexer
  // ========================================================

  // Only the owning port sees the response
  always_comb
  begin
    o_t_rspval = '0;
    o_t_rspval[i_rsp_sel] = i_m_rspval;
  end

  // Owning port's ack goes back with no delay
  assign o_m_rspack = i_t_rspack[i_rsp_sel];

  // ========================================================
  // Retirement
  // ========================================================

  // Last response beat accepted, drop the FIFO head
  assign o_unload = i_m_rspval && o_m_rspack && i_m_reop;

  always_comb
  begin
    a_rspval_onehot: assert final ($onehot0(o_t_rspval))
      else $error("response valid routed to more than one port");
  end

endmodule

// ==== logic/pkt_track_fifo.sv ====
// ==========================================================
// Packet tracking FIFO
// Shift-register queue of port indices for packets issued
// and not yet answered, head is the oldest packet
// ==========================================================
`timescale 1ns/1ps

module pkt_track_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                clk,
  input  logic                rst_a,
  input  logic                i_load,
  input  iarb_pkg::port_idx_t i_din,
  input  logic                i_unload,
  output iarb_pkg::port_idx_t o_head,
  output logic                o_full,
  output logic                o_empty
);

  // Counter holds 0 to FIFO_DEPTH inclusive
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  iarb_pkg::port_idx_t slot_r [FIFO_DEPTH];
  logic [CNT_W-1:0]    count_r;
  logic [CNT_W-1:0]    wr_ptr;
  logic                wr_en;

  // ========================================================
  // Write position
  // ========================================================

  // One slot lower when the queue shifts in the same cycle
  assign wr_ptr = i_unload ? (count_r - 1'b1) : count_r;

  // Load and unload on an empty queue retire each other
  assign wr_en = i_load && !(i_unload && o_empty);

  // ========================================================
  // Storage
  // ========================================================

  always_ff @(posedge clk)
  begin
    // Shift toward the head on unload
    if (i_unload)
    begin
      for (int i = 0; i < FIFO_DEPTH - 1; i++)
      begin
        slot_r[i] <= slot_r[i+1];
      end
    end
    // New entry overrides the shifted value in its slot
    for (int i = 0; i < FIFO_DEPTH; i++)
    begin
      if (wr_en && (wr_ptr == CNT_W'(i)))
      begin
        slot_r[i] <= i_din;
      end
    end
  end

  // Occupancy, unchanged on simultaneous load and unload
  always_ff @(posedge clk or posedge rst_a)
  begin
    if (rst_a)
    begin
      count_r <= '0;
    end
    else if (i_load && !i_unload)
    begin
      count_r <= count_r + 1'b1;
    end
    else if (i_unload && !i_load)
    begin
      count_r <= count_r - 1'b1;
    end
  end

  assign o_head  = slot_r[0];
  assign o_full  = (count_r == CNT_W'(FIFO_DEPTH));
  assign o_empty = (count_r == '0);

  a_no_overflow: assert property (@(posedge clk) disable iff (rst_a)
    (i_load && o_full) |-> i_unload)
    else $error("packet FIFO loaded while full");

  // Response in the issue cycle of the only packet is bypass
  a_no_underflow: assert property (@(posedge clk) disable iff (rst_a)
    (i_unload && o_empty) |-> i_load)
    else $error("packet FIFO unloaded while empty");

endmodule

// ==== logic/cmd_mux.sv ====
// ==========================================================
// Command multiplexer
// Steers the granted port's beat to the initiator and
// returns the initiator acknowledge to that port only
// ==========================================================
`timescale 1ns/1ps

module cmd_mux #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  iarb_pkg::port_idx_t                          i_sel,
  input  logic                                         i_inhibit,
  input  logic [iarb_pkg::NUM_PORTS-1:0]               i_t_cmdval,
  input  iarb_pkg::cmd_t [iarb_pkg::NUM_PORTS-1:0]     i_t_cmd,
  input  logic [iarb_pkg::NUM_PORTS-1:0]               i_t_eop,
  input  logic [iarb_pkg::NUM_PORTS-1:0][ADDR_W-1:0]   i_t_addr,
  input  logic [iarb_pkg::NUM_PORTS-1:0][DATA_W-1:0]   i_t_wdata,
  input  logic                                         i_m_cmdack,
  output logic                                         o_m_cmdval,
  output iarb_pkg::cmd_t                               o_m_cmd,
  output logic                                         o_m_eop,
  output logic [ADDR_W-1:0]                            o_m_addr,
  output logic [DATA_W-1:0]                            o_m_wdata,
  output logic [iarb_pkg::NUM_PORTS-1:0]               o_t_cmdack
);

  // ========================================================
  // Command fields
  // ========================================================

  // Valid is the only field gated by back-pressure
  assign o_m_cmdval = !i_inhibit && i_t_cmdval[i_sel];
  assign o_m_cmd    = i_t_cmd[i_sel];
  assign o_m_eop    = i_t_eop[i_sel];
  assign o_m_addr   = i_t_addr[i_sel];
  assign o_m_wdata  = i_t_wdata[i_sel];

  // ========================================================
  // Acknowledge switch
  // ========================================================

  // No port sees an ack while a new packet is blocked
  always_comb
  begin
    o_t_cmdack = '0;
    if (!i_inhibit)
    begin
      o_t_cmdack[i_sel] = i_m_cmdack;
    end
  end

  always_comb
  begin
    a_cmdack_onehot: assert final ($onehot0(o_t_cmdack))
      else $error("command ack driven to more than one port");
  end

endmodule

// ==== logic/cmd_arbiter.sv ====
// ==========================================================
// Command arbiter
// Fixed-priority winner, ARB/HOLD packet state machine
// and bus lock register, drives select and FIFO load
// ==========================================================
`timescale 1ns/1ps

module cmd_arbiter (
  input  logic                           clk,
  input  logic                           rst_a,
  input  logic [iarb_pkg::NUM_PORTS-1:0] i_cmdval,
  input  logic                           i_sel_cmdval,
  input  iarb_pkg::cmd_t                 i_sel_cmd,
  input  logic                           i_sel_eop,
  input  logic                           i_m_cmdack,
  input  logic                           i_fifo_full,
  output iarb_pkg::port_idx_t            o_sel,
  output logic                           o_inhibit,
  output logic                           o_load
);

  // Arbitration state, HOLD while a packet is in flight
  typedef enum logic {
    ST_ARB  = 1'b0,
    ST_HOLD = 1'b1
  } state_t;

  state_t              state_r;
  state_t              state_next;
  logic                lock_r;
  logic                lock_next;
  iarb_pkg::port_idx_t arb_win;
  iarb_pkg::port_idx_t hold_r;
  iarb_pkg::port_idx_t hold_next;
  logic                new_pkt;
  logic                pkt_end;

  // ========================================================
  // Priority encoder
  // ========================================================

  // Scan downward so the lowest valid port is written last
  always_comb
  begin
    arb_win = '0;
    for (int i = iarb_pkg::NUM_PORTS - 1; i >= 0; i--)
    begin
      if (i_cmdval[i])
      begin
        arb_win = iarb_pkg::port_idx_t'(i);
      end
    end
  end

  // First beat of a packet accepted into tracking
  assign new_pkt = (state_r == ST_ARB) && i_sel_cmdval && !i_fifo_full;

  // Acknowledged end-of-packet beat
  assign pkt_end = i_sel_cmdval && i_m_cmdack && i_sel_eop;

  // ========================================================
  // Next state, winner hold and lock
  // ========================================================

  always_comb
  begin
    state_next = state_r;
    lock_next  = lock_r;
    hold_next  = hold_r;
    case (state_r)
      ST_ARB:
      begin
        // Stay in ARB only for a single-beat packet acked now
        if (new_pkt && !pkt_end)
        begin
          state_next = ST_HOLD;
        end
        // Track live winner unless the bus is locked
        if (!lock_r)
        begin
          hold_next = arb_win;
        end
        // Lock and unlock take effect on a packet's first beat
        if (new_pkt)
        begin
          if (!lock_r && (i_sel_cmd == iarb_pkg::CMD_LOCK))
          begin
            lock_next = 1'b1;
          end
          else if (lock_r && (i_sel_cmd == iarb_pkg::CMD_UNLOCK))
          begin
            lock_next = 1'b0;
          end
        end
      end
      ST_HOLD:
      begin
        // Release after the last beat is acknowledged
        if (pkt_end)
        begin
          state_next = ST_ARB;
        end
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst_a)
  begin
    if (rst_a)
    begin
      state_r <= ST_ARB;
      lock_r  <= 1'b0;
      hold_r  <= '0;
    end
    else
    begin
      state_r <= state_next;
      lock_r  <= lock_next;
      hold_r  <= hold_next;
    end
  end

  // ========================================================
  // Control outputs
  // ========================================================

  // Block only a new packet, an ongoing one runs to its end
  assign o_inhibit = (state_r == ST_ARB) && i_fifo_full;

  // Registered winner while holding or locked
  assign o_sel = ((state_r == ST_HOLD) || lock_r) ? hold_r : arb_win;

  assign o_load = new_pkt;

  // Select must always name a real port
  a_sel_range: assert property (@(posedge clk) disable iff (rst_a)
    o_sel < iarb_pkg::NUM_PORTS)
    else $error("arbiter select out of port range");

endmodule

// ==== logic/iarb_pkg.sv ====
// ==========================================================
// Instruction-bus arbiter shared definitions
// Port count, port index type and bus command codes
// ==========================================================
package iarb_pkg;

  // ========================================================
  // Port count
  // ========================================================

  // Requesting ports, port 0 has the highest priority
  localparam int NUM_PORTS = 5;

  // ========================================================
  // Types
  // ========================================================

  // Port index, legal values 0 to NUM_PORTS-1
  typedef logic [2:0] port_idx_t;

  // Command code carried with every beat
  // LOCK keeps the bus on the issuing port until UNLOCK
  typedef enum logic [1:0] {
    CMD_READ   = 2'b00,
    CMD_WRITE  = 2'b01,
    CMD_UNLOCK = 2'b10,
    CMD_LOCK   = 2'b11
  } cmd_t;

endpackage
